// File: list.f
hw/scu_dsp_pkg.sv
hw/dsp_bank_if.sv
hw/dsp_alu.sv
hw/dsp_datapath.sv
hw/data_bank.sv
hw/bus_select.sv
hw/dsp_decoder.sv
hw/apb_host_port.sv
hw/scu_dsp_top.sv
verification/tb_scu_dsp.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps --top-module tb_scu_dsp \
	-f list.f --Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "Simulation exited with an error, see sim.log"
	exit 1
fi

cat sim.log
if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0

// File: verification/tb_scu_dsp.sv
`timescale 1ns/10ps

module tb_scu_dsp import scu_dsp_pkg::*; ();
	localparam int TIMEOUT_CYCLES = 3000;	// Tests take about 730 cycles
	localparam logic [7:0] SRC_ACL = 8'h09;
	localparam logic [7:0] SRC_ACH = 8'h0A;

	logic CLOCK;
	logic RESET_N;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	dsp_word_t pwdata;
	dsp_word_t prdata;
	logic pready;
	inst_addr_t inst_addr;
	dsp_word_t inst_in;

	dsp_word_t model_mem [NUM_BANKS][BANK_DEPTH];	// Expected RAM contents
	logic [31:0] rng_state = 32'hdadcad21;
	int cycle_count = 0;
	int errors = 0;
	int checks = 0;
	alu_op_t alu_ops [11] = '{ALU_AND, ALU_OR, ALU_XOR, ALU_ADD, ALU_SUB, ALU_AD2,
		ALU_SR, ALU_RR, ALU_SL, ALU_RL, ALU_RL8};

	scu_dsp_top u_dut (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.inst_addr(inst_addr), .inst_in(inst_in)
	);

	always #2 CLOCK = ~CLOCK;

	always @(posedge CLOCK) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Run stopped at cycle %0d before the tests finished", cycle_count);
		$display("Testbench failed");
		$finish;
	end

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Instruction fields at the documented bit positions
	function automatic dsp_word_t x_field(x_op_t op, logic inc, bank_sel_t src);
		dsp_word_t w;
		w = '0;
		w[25:23] = op;
		w[22] = inc;
		w[21:20] = src;
		return w;
	endfunction

	function automatic dsp_word_t y_field(y_op_t op, logic inc, bank_sel_t src);
		dsp_word_t w;
		w = '0;
		w[19:17] = op;
		w[16] = inc;
		w[15:14] = src;
		return w;
	endfunction

	function automatic dsp_word_t d1_field(d1_op_t op, logic [3:0] dst, logic [7:0] low);
		dsp_word_t w;
		w = '0;
		w[13:12] = op;
		w[11:8] = dst;
		w[7:0] = low;	// Immediate, or source code in 3:0
		return w;
	endfunction

	function automatic dsp_word_t alu_field(alu_op_t op);
		dsp_word_t w;
		w = '0;
		w[29:26] = op;
		return w;
	endfunction

	function automatic acc_t alu_model(alu_op_t op, acc_t a, acc_t p);
		dsp_word_t l;
		dsp_word_t r;
		dsp_word_t q;
		l = a[31:0];
		r = p[31:0];
		case (op)
			ALU_AND: q = l & r;
			ALU_OR: q = l | r;
			ALU_XOR: q = l ^ r;
			ALU_ADD: q = l + r;
			ALU_SUB: q = l - r;
			ALU_AD2: return a + p;
			ALU_SR: q = $signed(l) >>> 1;
			ALU_RR: q = (l >> 1) | (l << 31);
			ALU_SL: q = l << 1;
			ALU_RL: q = (l << 1) | (l >> 31);
			ALU_RL8: q = (l << 8) | (l >> 24);
			default: return a;
		endcase
		return {16'h0000, q};
	endfunction

	task automatic check_word(string name, dsp_word_t got, dsp_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(string name, inst_addr_t got, inst_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic issue(dsp_word_t w);
		inst_in = w;
		@(posedge CLOCK);
		#1;
	endtask

	// NOPs until the last instruction has committed
	task automatic drain();
		inst_in = '0;
		repeat (2) @(posedge CLOCK);
		#1;
	endtask

	// Called in the first access cycle, returns in the second
	task automatic wait_ready(string kind);
		int waits;
		waits = 0;
		checks++;
		if (pready) begin
			errors++;
			$display("APB %s at %0t: pready was already high in the first access cycle",
				kind, $time);
		end
		@(posedge CLOCK);
		#1;
		while (!pready && waits < 4) begin
			@(posedge CLOCK);
			#1;
			waits++;
		end
		if (waits != 0) begin
			errors++;
			$display("APB %s at %0t: pready did not rise in the second access cycle",
				kind, $time);
		end
	endtask

	task automatic apb_write(bank_sel_t b, ct_t addr, dsp_word_t data);
		psel = 1'b1;
		pwrite = 1'b1;
		penable = 1'b0;
		paddr = {b, addr};
		pwdata = data;
		@(posedge CLOCK);
		#1;
		penable = 1'b1;
		wait_ready("write");
		@(posedge CLOCK);	// RAM written here
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		model_mem[b][addr] = data;
	endtask

	task automatic apb_read(bank_sel_t b, ct_t addr, output dsp_word_t data);
		psel = 1'b1;
		pwrite = 1'b0;
		penable = 1'b0;
		paddr = {b, addr};
		@(posedge CLOCK);
		#1;
		penable = 1'b1;
		wait_ready("read");
		data = prdata;
		@(posedge CLOCK);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_check(bank_sel_t b, ct_t addr);
		dsp_word_t got;
		apb_read(b, addr, got);
		check_word($sformatf("prdata bank %0d word %0d", b, addr), got, model_mem[b][addr]);
	endtask

	// Stores ACL and ACH to bank 3 words 48 and 49 and reads them back
	task automatic read_back_acc(acc_t exp);
		dsp_word_t got;
		issue(d1_field(D1_IMM, 4'b1111, 8'd48));
		issue(d1_field(D1_MOV, 4'b0011, SRC_ACL));
		issue(d1_field(D1_MOV, 4'b0011, SRC_ACH));
		drain();
		model_mem[3][48] = exp[31:0];
		model_mem[3][49] = {16'h0000, exp[47:32]};
		apb_read(2'd3, 6'd48, got);
		check_word("ACL", got, model_mem[3][48]);
		apb_read(2'd3, 6'd49, got);
		check_word("ACH", got, model_mem[3][49]);
	endtask

	task automatic report_test(string name, int first_errors);
		$display("%s finished with %0d errors", name, errors - first_errors);
	endtask

	task automatic count_inst_addr();
		inst_addr_t exp;
		int first;
		first = errors;
		exp = '0;
		check_addr("inst_addr", inst_addr, exp);
		repeat (300) begin	// Crosses the 8-bit wrap
			@(posedge CLOCK);
			#1;
			exp = exp + 1'b1;
			check_addr("inst_addr", inst_addr, exp);
		end
		report_test("inst_addr count", first);
	endtask

	task automatic write_read_banks();
		int first;
		first = errors;
		for (int b = 0; b < NUM_BANKS; b++)
			for (int w = 0; w < 4; w++)
				apb_write(bank_sel_t'(b), ct_t'(w * 16 + b), next_random());
		for (int b = 0; b < NUM_BANKS; b++)
			for (int w = 0; w < 4; w++)
				read_check(bank_sel_t'(b), ct_t'(w * 16 + b));
		report_test("APB write and read", first);
	endtask

	task automatic store_immediates();
		logic [31:0] r;
		int first;
		first = errors;
		issue(d1_field(D1_IMM, 4'b1101, 8'd10));	// CT1 = 10
		for (int i = 0; i < 6; i++) begin
			r = next_random();
			issue(d1_field(D1_IMM, 4'b0001, r[7:0]));
			model_mem[1][10 + i] = {24'h000000, r[7:0]};
		end
		drain();
		for (int i = 0; i < 6; i++)
			read_check(2'd1, ct_t'(10 + i));
		report_test("immediate to bank", first);
	endtask

	task automatic copy_banks();
		int first;
		first = errors;
		issue(d1_field(D1_IMM, 4'b1101, 8'd10));
		issue(d1_field(D1_IMM, 4'b1110, 8'd40));
		for (int i = 0; i < 6; i++) begin
			issue(d1_field(D1_MOV, 4'b0010, 8'h05));	// MD1 with increment to MD2
			model_mem[2][40 + i] = model_mem[1][10 + i];
		end
		drain();
		for (int i = 0; i < 6; i++)
			read_check(2'd2, ct_t'(40 + i));
		issue(d1_field(D1_IMM, 4'b1100, 8'd0));
		issue(y_field(Y_MOV_A, 1'b0, 2'd0));
		read_back_acc({16'h0000, model_mem[0][0]});
		report_test("bank copy and accumulator store", first);
	endtask

	task automatic run_alu_ops();
		acc_t a;
		acc_t p;
		int first;
		first = errors;
		foreach (alu_ops[i]) begin
			apb_write(2'd0, 6'd20, next_random());
			apb_write(2'd0, 6'd21, next_random());
			a = {16'h0000, model_mem[0][20]};
			p = {16'h0000, model_mem[0][21]};
			issue(d1_field(D1_IMM, 4'b1100, 8'd20));
			issue(y_field(Y_MOV_A, 1'b1, 2'd0));	// ACL from word 20, CT0 to 21
			issue(x_field(X_MOV_P, 1'b0, 2'd0));
			issue(alu_field(alu_ops[i]) | y_field(Y_ALU_A, 1'b0, 2'd0));
			read_back_acc(alu_model(alu_ops[i], a, p));
		end
		report_test("ALU operations", first);
	endtask

	task automatic multiply_to_acc();
		logic [63:0] product;
		int first;
		first = errors;
		apb_write(2'd1, 6'd30, next_random());
		apb_write(2'd1, 6'd31, next_random());
		product = {32'h0, model_mem[1][30]} * {32'h0, model_mem[1][31]};
		issue(d1_field(D1_IMM, 4'b1101, 8'd30));
		issue(x_field(X_MOV_X, 1'b1, 2'd1));
		issue(y_field(Y_MOV_Y, 1'b0, 2'd1));
		issue(x_field(X_MUL_P, 1'b0, 2'd0));
		issue(y_field(Y_CLR_A, 1'b0, 2'd0));
		issue(alu_field(ALU_AD2) | y_field(Y_ALU_A, 1'b0, 2'd0));
		read_back_acc(product[47:0]);
		report_test("multiply", first);
	endtask

	initial begin
		CLOCK = 1'b0;
		RESET_N = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		inst_in = '0;
		repeat (5) @(posedge CLOCK);
		#1;
		RESET_N = 1'b1;

		count_inst_addr();
		write_read_banks();
		store_immediates();
		copy_banks();
		run_alu_ops();
		multiply_to_acc();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end
endmodule

// File: hw/scu_dsp_top.sv
`timescale 1ns/10ps

module scu_dsp_top import scu_dsp_pkg::*; (
	input logic CLOCK,
	input logic RESET_N,

	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input dsp_word_t pwdata,
	output dsp_word_t prdata,
	output logic pready,

	output inst_addr_t inst_addr,
	input dsp_word_t inst_in
);
	dsp_bank_if bank_bus [NUM_BANKS] ();

	dsp_word_t x_bus;
	dsp_word_t y_bus;
	dsp_word_t d1_bus;
	acc_t acc;

	logic [NUM_BANKS-1:0] host_sel;
	logic host_write;
	ct_t host_addr;
	dsp_word_t host_wdata;

	bank_sel_t x_src;
	bank_sel_t y_src;
	logic [3:0] d1_src;
	logic [7:0] d1_imm;
	logic x_to_rx;
	logic d1_to_rx;
	logic load_ry;
	logic mul_to_p;
	logic x_to_pl;
	logic d1_to_pl;
	logic clr_a;
	logic alu_to_a;
	logic y_to_acl;
	alu_op_t alu_op;

	apb_host_port #(.NUM_BANKS(NUM_BANKS)) u_apb (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready),
		.bank(bank_bus), .host_sel(host_sel), .host_write(host_write),
		.host_addr(host_addr), .host_wdata(host_wdata)
	);

	dsp_decoder u_decoder (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.inst_in(inst_in), .inst_addr(inst_addr), .bank(bank_bus),
		.x_src(x_src), .y_src(y_src), .d1_src(d1_src), .d1_imm(d1_imm),
		.x_to_rx(x_to_rx), .d1_to_rx(d1_to_rx), .load_ry(load_ry),
		.mul_to_p(mul_to_p), .x_to_pl(x_to_pl), .d1_to_pl(d1_to_pl),
		.clr_a(clr_a), .alu_to_a(alu_to_a), .y_to_acl(y_to_acl), .alu_op(alu_op)
	);

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
		data_bank #(.BANK_DEPTH(BANK_DEPTH)) u_bank (
			.CLOCK(CLOCK), .RESET_N(RESET_N),
			.bank(bank_bus[i]), .d1(d1_bus),
			.host_sel(host_sel[i]), .host_write(host_write),
			.host_addr(host_addr), .host_wdata(host_wdata)
		);
	end

	bus_select #(.NUM_BANKS(NUM_BANKS)) u_bus_select (
		.bank(bank_bus), .x_src(x_src), .y_src(y_src), .d1_src(d1_src),
		.d1_imm(d1_imm), .acc(acc), .x_bus(x_bus), .y_bus(y_bus), .d1_bus(d1_bus)
	);

	dsp_datapath u_datapath (
		.CLOCK(CLOCK), .RESET_N(RESET_N),
		.x_bus(x_bus), .y_bus(y_bus), .d1_bus(d1_bus),
		.x_to_rx(x_to_rx), .d1_to_rx(d1_to_rx), .load_ry(load_ry),
		.mul_to_p(mul_to_p), .x_to_pl(x_to_pl), .d1_to_pl(d1_to_pl),
		.clr_a(clr_a), .alu_to_a(alu_to_a), .y_to_acl(y_to_acl),
		.alu_op(alu_op), .acc(acc)
	);
endmodule

// File: hw/apb_host_port.sv
`timescale 1ns/10ps

module apb_host_port import scu_dsp_pkg::*; #(
	parameter int NUM_BANKS = 4
) (
	input logic CLOCK,
	input logic RESET_N,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [7:0] paddr,
	input dsp_word_t pwdata,
	output dsp_word_t prdata,
	output logic pready,
	dsp_bank_if.drain bank [NUM_BANKS],
	output logic [NUM_BANKS-1:0] host_sel,
	output logic host_write,
	output ct_t host_addr,
	output dsp_word_t host_wdata
);
	dsp_word_t q [NUM_BANKS];
	bank_sel_t pbank;
	logic access;

	assign access = psel && penable;
	assign pbank = paddr[$bits(ct_t) +: $bits(bank_sel_t)];	// Bank in bits 7:6
	assign host_addr = paddr[$bits(ct_t)-1:0];
	assign host_wdata = pwdata;
	assign host_write = access && pwrite && pready;	// Second access cycle only

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_sel
		assign q[i] = bank[i].q;
		assign host_sel[i] = access && (pbank == bank_sel_t'(i));
	end

	// pready marks the second access cycle
	always_ff @(posedge CLOCK) begin
		if (!RESET_N)
			pready <= 1'b0;
		else
			pready <= access && !pready;
	end

	always_ff @(posedge CLOCK) begin
		if (access && !pready && !pwrite)
			prdata <= q[pbank];	// Captured at the end of the first access cycle
	end
endmodule

// File: hw/dsp_decoder.sv
`timescale 1ns/10ps

module dsp_decoder import scu_dsp_pkg::*; (
	input logic CLOCK,
	input logic RESET_N,
	input dsp_word_t inst_in,
	output inst_addr_t inst_addr,
	dsp_bank_if.ctrl bank [NUM_BANKS],
	output bank_sel_t x_src,
	output bank_sel_t y_src,
	output logic [3:0] d1_src,
	output logic [7:0] d1_imm,
	output logic x_to_rx,
	output logic d1_to_rx,
	output logic load_ry,
	output logic mul_to_p,
	output logic x_to_pl,
	output logic d1_to_pl,
	output logic clr_a,
	output logic alu_to_a,
	output logic y_to_acl,
	output alu_op_t alu_op
);
	dsp_word_t fetch;
	logic is_op;
	x_op_t x_op;
	y_op_t y_op;
	d1_op_t d1_op;
	logic [3:0] d1_dst;
	logic [3:0] d1_field;
	logic [NUM_BANKS-1:0] load_ct;
	logic [NUM_BANKS-1:0] inc_ct;
	logic [NUM_BANKS-1:0] load_md;

	always_ff @(posedge CLOCK) begin
		if (!RESET_N) begin
			inst_addr <= '0;
			fetch <= '0;	// Decodes as a NOP
		end else begin
			inst_addr <= inst_addr + 1'b1;	// Free running, wraps at 255
			fetch <= inst_in;
		end
	end

	assign is_op = fetch[CLASS_LSB +: 2] == CLASS_OPERATION;
	assign x_op = x_op_t'(fetch[X_OP_LSB +: $bits(x_op_t)]);
	assign y_op = y_op_t'(fetch[Y_OP_LSB +: $bits(y_op_t)]);
	assign d1_op = d1_op_t'(fetch[D1_OP_LSB +: $bits(d1_op_t)]);
	assign d1_dst = fetch[D1_DST_LSB +: 4];
	assign d1_field = fetch[D1_SRC_LSB +: 4];
	assign x_src = fetch[X_SRC_LSB +: $bits(bank_sel_t)];
	assign y_src = fetch[Y_SRC_LSB +: $bits(bank_sel_t)];	// Bits 15:14
	assign d1_imm = fetch[IMM_LSB +: 8];
	assign alu_op = alu_op_t'(fetch[ALU_OP_LSB +: $bits(alu_op_t)]);

	always_comb begin
		load_ct = '0;
		inc_ct = '0;
		load_md = '0;
		x_to_rx = 1'b0;
		d1_to_rx = 1'b0;
		load_ry = 1'b0;
		mul_to_p = 1'b0;
		x_to_pl = 1'b0;
		d1_to_pl = 1'b0;
		clr_a = 1'b0;
		alu_to_a = 1'b0;
		y_to_acl = 1'b0;
		d1_src = D1_SRC_NONE;
		if (is_op) begin
			case (x_op)
				X_MOV_X: x_to_rx = 1'b1;
				X_MUL_P: mul_to_p = 1'b1;
				X_MOV_P: x_to_pl = 1'b1;
				default: ;
			endcase
			if ((x_op == X_MOV_X || x_op == X_MOV_P) && fetch[X_INC_BIT])
				inc_ct[x_src] = 1'b1;	// Counter of the source bank

			case (y_op)
				Y_MOV_Y: load_ry = 1'b1;
				Y_CLR_A: clr_a = 1'b1;
				Y_ALU_A: alu_to_a = 1'b1;
				Y_MOV_A: y_to_acl = 1'b1;
				default: ;
			endcase
			if ((y_op == Y_MOV_Y || y_op == Y_MOV_A) && fetch[Y_INC_BIT])
				inc_ct[y_src] = 1'b1;

			if (d1_op == D1_IMM || d1_op == D1_MOV) begin
				case (d1_dst) inside
					4'b00??: begin	// MDn, CTn++
						load_md[d1_dst[1:0]] = 1'b1;
						inc_ct[d1_dst[1:0]] = 1'b1;
					end
					4'b0100: d1_to_rx = 1'b1;
					4'b0101: d1_to_pl = 1'b1;
					4'b11??: load_ct[d1_dst[1:0]] = 1'b1;
					default: ;
				endcase
			end

			if (d1_op == D1_IMM) begin
				d1_src = D1_SRC_IMM;
			end else if (d1_op == D1_MOV) begin
				case (d1_field) inside
					4'b0???: begin
						d1_src = d1_field;
						if (d1_field[2])
							inc_ct[d1_field[1:0]] = 1'b1;	// Source post increment
					end
					D1_SRC_ACL, D1_SRC_ACH: d1_src = d1_field;
					default: d1_src = D1_SRC_NONE;
				endcase
			end
		end
	end

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_ctrl
		assign bank[i].load_ct = load_ct[i];
		assign bank[i].inc_ct = inc_ct[i];
		assign bank[i].load_md = load_md[i];
	end
endmodule

// File: hw/bus_select.sv
`timescale 1ns/10ps

module bus_select import scu_dsp_pkg::*; #(
	parameter int NUM_BANKS = 4
) (
	dsp_bank_if.drain bank [NUM_BANKS],
	input bank_sel_t x_src,
	input bank_sel_t y_src,
	input logic [3:0] d1_src,
	input logic [7:0] d1_imm,
	input acc_t acc,
	output dsp_word_t x_bus,
	output dsp_word_t y_bus,
	output dsp_word_t d1_bus
);
	dsp_word_t q [NUM_BANKS];

	for (genvar i = 0; i < NUM_BANKS; i++) begin : g_q
		assign q[i] = bank[i].q;
	end

	assign x_bus = q[x_src];
	assign y_bus = q[y_src];

	always_comb begin
		case (d1_src) inside
			4'b0???: d1_bus = q[d1_src[1:0]];	// Bit 2 is the increment flag
			D1_SRC_IMM: d1_bus = {24'h000000, d1_imm};
			D1_SRC_ACL: d1_bus = acc[31:0];
			D1_SRC_ACH: d1_bus = {16'h0000, acc[47:32]};
			default: d1_bus = '0;
		endcase
	end
endmodule

// File: hw/data_bank.sv
`timescale 1ns/10ps

module data_bank import scu_dsp_pkg::*; #(
	parameter int BANK_DEPTH = 64
) (
	input logic CLOCK,
	input logic RESET_N,
	dsp_bank_if.bank bank,
	input dsp_word_t d1,
	input logic host_sel,
	input logic host_write,
	input ct_t host_addr,
	input dsp_word_t host_wdata
);
	dsp_word_t ram [BANK_DEPTH];
	ct_t ct;
	ct_t addr;

	assign addr = host_sel ? host_addr : ct;	// Host owns the bank during a transfer
	assign bank.q = ram[addr];

	always_ff @(posedge CLOCK) begin
		if (!RESET_N)
			ct <= '0;
		else if (bank.load_ct)
			ct <= d1[$bits(ct_t)-1:0];	// Load beats increment
		else if (bank.inc_ct)
			ct <= ct + 1'b1;
	end

	always_ff @(posedge CLOCK) begin
		if (host_sel && host_write)
			ram[addr] <= host_wdata;
		else if (bank.load_md && !host_sel)
			ram[addr] <= d1;
	end
endmodule

// File: hw/dsp_datapath.sv
`timescale 1ns/10ps

module dsp_datapath import scu_dsp_pkg::*; (
	input logic CLOCK,
	input logic RESET_N,
	input dsp_word_t x_bus,
	input dsp_word_t y_bus,
	input dsp_word_t d1_bus,
	input logic x_to_rx,
	input logic d1_to_rx,
	input logic load_ry,
	input logic mul_to_p,
	input logic x_to_pl,
	input logic d1_to_pl,
	input logic clr_a,
	input logic alu_to_a,
	input logic y_to_acl,
	input alu_op_t alu_op,
	output acc_t acc
);
	dsp_word_t rx;
	dsp_word_t ry;
	acc_t p;
	acc_t a;
	acc_t alu_res;
	logic [63:0] product;

	assign product = 64'(rx) * 64'(ry);
	assign acc = a;

	always_ff @(posedge CLOCK) begin
		if (!RESET_N) begin
			rx <= '0;
			ry <= '0;
			p <= '0;
			a <= '0;
		end else begin
			if (x_to_rx)
				rx <= x_bus;	// X field wins over D1
			else if (d1_to_rx)
				rx <= d1_bus;
			if (load_ry)
				ry <= y_bus;
			if (mul_to_p)
				p <= product[47:0];
			else if (x_to_pl)
				p <= {16'h0000, x_bus};	// PH cleared
			else if (d1_to_pl)
				p <= {16'h0000, d1_bus};
			if (clr_a)
				a <= '0;
			else if (alu_to_a)
				a <= alu_res;
			else if (y_to_acl)
				a <= {16'h0000, y_bus};	// ACH cleared
		end
	end

	dsp_alu u_alu (
		.a(a),
		.p(p),
		.op(alu_op),
		.result(alu_res)
	);
endmodule

// File: hw/dsp_alu.sv
`timescale 1ns/10ps

module dsp_alu import scu_dsp_pkg::*; (
	input acc_t a,
	input acc_t p,
	input alu_op_t op,
	output acc_t result
);
	dsp_word_t acl;
	dsp_word_t pl;

	assign acl = a[31:0];
	assign pl = p[31:0];

	// 32-bit results leave the top 16 bits clear
	always_comb begin
		case (op)
			ALU_AND: result = {16'h0000, acl & pl};
			ALU_OR: result = {16'h0000, acl | pl};
			ALU_XOR: result = {16'h0000, acl ^ pl};
			ALU_ADD: result = {16'h0000, acl + pl};
			ALU_SUB: result = {16'h0000, acl - pl};
			ALU_AD2: result = a + p;	// Full 48 bits
			ALU_SR: result = {16'h0000, acl[31], acl[31:1]};	// Sign kept
			ALU_RR: result = {16'h0000, acl[0], acl[31:1]};
			ALU_SL: result = {16'h0000, acl[30:0], 1'b0};
			ALU_RL: result = {16'h0000, acl[30:0], acl[31]};
			ALU_RL8: result = {16'h0000, acl[23:0], acl[31:24]};
			default: result = a;	// NOP and unused codes
		endcase
	end
endmodule

// File: hw/dsp_bank_if.sv
`timescale 1ns/10ps

interface dsp_bank_if import scu_dsp_pkg::*; ();
	logic load_ct;	// CT takes D1
	logic inc_ct;	// Merged increment request
	logic load_md;	// RAM takes D1
	dsp_word_t q;	// Word at the current bank address

	modport ctrl (output load_ct, output inc_ct, output load_md);

	modport bank (input load_ct, input inc_ct, input load_md, output q);

	modport drain (input q);
endinterface

// File: hw/scu_dsp_pkg.sv
package scu_dsp_pkg;
	localparam int NUM_BANKS = 4;
	localparam int BANK_DEPTH = 64;

	typedef logic [31:0] dsp_word_t;
	typedef logic [47:0] acc_t;	// ACH(16) and ACL(32), PH(16) and PL(32)
	typedef logic [5:0] ct_t;
	typedef logic [1:0] bank_sel_t;
	typedef logic [7:0] inst_addr_t;

	typedef enum logic [3:0] {
		ALU_NOP = 4'h0, ALU_AND = 4'h1, ALU_OR = 4'h2, ALU_XOR = 4'h3,
		ALU_ADD = 4'h4, ALU_SUB = 4'h5, ALU_AD2 = 4'h6, ALU_SR = 4'h8,
		ALU_RR = 4'h9, ALU_SL = 4'hA, ALU_RL = 4'hB, ALU_RL8 = 4'hF
	} alu_op_t;

	typedef enum logic [2:0] {X_NOP = 3'b000, X_MUL_P = 3'b010, X_MOV_P = 3'b011,
		X_MOV_X = 3'b100} x_op_t;
	typedef enum logic [2:0] {Y_NOP = 3'b000, Y_CLR_A = 3'b001, Y_ALU_A = 3'b010,
		Y_MOV_A = 3'b011, Y_MOV_Y = 3'b100} y_op_t;
	typedef enum logic [1:0] {D1_NOP = 2'b00, D1_IMM = 2'b01, D1_MOV = 2'b11} d1_op_t;

	// Operation command field positions
	localparam int CLASS_LSB = 30;
	localparam logic [1:0] CLASS_OPERATION = 2'b00;
	localparam int ALU_OP_LSB = 26;
	localparam int X_OP_LSB = 23;
	localparam int X_INC_BIT = 22;
	localparam int X_SRC_LSB = 20;
	localparam int Y_OP_LSB = 17;
	localparam int Y_INC_BIT = 16;
	localparam int Y_SRC_LSB = 14;
	localparam int D1_OP_LSB = 12;
	localparam int D1_DST_LSB = 8;
	localparam int D1_SRC_LSB = 0;
	localparam int IMM_LSB = 0;

	// Bank sources are 0xxx with bit 2 as increment
	localparam logic [3:0] D1_SRC_NONE = 4'b1000;
	localparam logic [3:0] D1_SRC_ACL = 4'b1001;
	localparam logic [3:0] D1_SRC_ACH = 4'b1010;
	localparam logic [3:0] D1_SRC_IMM = 4'b1100;	// Internal code, not an instruction value
endpackage
